// ==== Bender.yml ====
package:
  name: pke_enc_ctrl

sources:
  - design/kyber_ctrl_pkg.sv
  - design/enc_sequencer.sv
  - design/msg_input_fsm.sv
  - design/hash_stage_fsm.sv
  - design/cbd_stage_fsm.sv
  - design/ntt_stage_fsm.sv
  - design/pke_enc_ctrl.sv
  - target: test
    files:
      - test/pke_enc_asserts.sv
      - test/pke_enc_checker.sv
      - test/tb_pke_enc_ctrl.sv

// ==== design/cbd_stage_fsm.sv ====
module cbd_stage_fsm #(
  parameter int ROUNDS = kyber_ctrl_pkg::DEFAULT_ROUNDS
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          set,
  input  logic                          cbd_ok_in,
  input  logic                          cbd_ok_out,  // high while samples are valid
  input  kyber_ctrl_pkg::ctrl_cmd_t     cbd_cmd,
  input  kyber_ctrl_pkg::stage_status_t hash_status,
  input  kyber_ctrl_pkg::stage_status_t ntt_status,
  output logic                          cbd_sel,
  output logic                          cbd_readin,
  output logic                          cbd_readout,
  output kyber_ctrl_pkg::stage_status_t cbd_status
);
  import kyber_ctrl_pkg::*;

  localparam int RW = $clog2(ROUNDS + 1);

  stage_state_t  state, next_state;
  logic [RW-1:0] round_cnt;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= S_IDLE;
      round_cnt <= '0;
    end else if (set) begin
      state <= next_state;
      if (state == S_START_CAL)
        round_cnt <= round_cnt + 1'b1;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE:        if (cbd_ok_in) next_state = S_READY_INPUT;
      S_READY_INPUT: begin
        if (hash_status == ST_OUTPUT && cbd_cmd == CMD_RUN) // hash is squeezing
          next_state = S_INPUT;
      end
      S_INPUT:        if (hash_status == ST_OUTPUT_DONE) next_state = S_START_CAL;
      S_START_CAL:    next_state = S_CALCULATE;
      S_CALCULATE:    if (cbd_ok_out) next_state = S_OUTPUT_READY;
      S_OUTPUT_READY: if (ntt_status == ST_READY_INPUT) next_state = S_OUTPUT;
      S_OUTPUT:       if (!cbd_ok_out) next_state = S_OUTPUT_DONE; // sample window closed
      S_OUTPUT_DONE: begin
        if (round_cnt == RW'(ROUNDS))
          next_state = S_SEQUENCE_DONE;
        else if (cbd_cmd == CMD_RUN)
          next_state = S_IDLE;
      end
      S_SEQUENCE_DONE: next_state = S_SEQUENCE_DONE;
      default:         next_state = S_IDLE;
    endcase
  end

  assign cbd_sel     = (state == S_IDLE) && (cbd_cmd == CMD_RUN);
  assign cbd_readin  = (state == S_INPUT);
  assign cbd_readout = (state == S_OUTPUT);

  always_comb begin
    case (state)
      S_READY_INPUT:            cbd_status = ST_READY_INPUT;
      S_INPUT:                  cbd_status = ST_INPUT;
      S_START_CAL, S_CALCULATE: cbd_status = ST_CALC;
      S_OUTPUT_READY:           cbd_status = ST_OUTPUT_READY;
      S_OUTPUT:                 cbd_status = ST_OUTPUT;
      S_OUTPUT_DONE:            cbd_status = ST_OUTPUT_DONE;
      S_SEQUENCE_DONE:          cbd_status = ST_SEQ_DONE;
      default:                  cbd_status = ST_IDLE;
    endcase
  end

endmodule

// ==== design/enc_sequencer.sv ====
module enc_sequencer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          set,
  input  kyber_ctrl_pkg::input_status_t input_status,
  input  kyber_ctrl_pkg::stage_status_t hash_status,
  input  kyber_ctrl_pkg::stage_status_t cbd_status,
  input  kyber_ctrl_pkg::stage_status_t ntt_status,
  output kyber_ctrl_pkg::ctrl_cmd_t     input_cmd,
  output kyber_ctrl_pkg::ctrl_cmd_t     hash_cmd,
  output kyber_ctrl_pkg::ctrl_cmd_t     cbd_cmd,
  output kyber_ctrl_pkg::ctrl_cmd_t     ntt_cmd,
  output logic                          done
);
  import kyber_ctrl_pkg::*;

  main_state_t state, next_state;
  logic        all_idle;

  assign all_idle = (input_status == IN_IDLE) && (hash_status == ST_IDLE) &&
                    (cbd_status == ST_IDLE) && (ntt_status == ST_IDLE);

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      state <= M_IDLE;
    else if (set)
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      M_IDLE:   if (all_idle) next_state = M_RUN;
      M_RUN:    if (input_status == IN_DONE) next_state = M_STAGE; // message loaded
      M_STAGE:  if (ntt_status == ST_SEQ_DONE) next_state = M_FINISH;
      M_FINISH: next_state = M_FINISH; // held until reset
      default:  next_state = M_IDLE;
    endcase
  end

  // input controller released in STAGE so it never reloads
  assign input_cmd = (state == M_RUN) ? CMD_RUN : CMD_NONE;
  assign hash_cmd  = (state == M_RUN || state == M_STAGE) ? CMD_RUN : CMD_NONE;
  assign cbd_cmd   = hash_cmd;
  assign ntt_cmd   = hash_cmd;
  assign done      = (state == M_FINISH);

endmodule

// ==== design/hash_stage_fsm.sv ====
module hash_stage_fsm #(
  parameter int ROUNDS     = kyber_ctrl_pkg::DEFAULT_ROUNDS,
  parameter int HASH_BEATS = kyber_ctrl_pkg::DEFAULT_HASH_BEATS
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          set,
  input  logic                          hash_readin_ok,
  input  logic                          hash_done,
  input  kyber_ctrl_pkg::ctrl_cmd_t     hash_cmd,
  input  kyber_ctrl_pkg::input_status_t input_status,
  input  kyber_ctrl_pkg::stage_status_t cbd_status,
  output logic                          hash_sel,
  output logic                          hash_readin,
  output logic                          hash_full_in,
  output logic                          hash_readout,
  output kyber_ctrl_pkg::stage_status_t hash_status
);
  import kyber_ctrl_pkg::*;

  localparam int RW = $clog2(ROUNDS + 1);

  stage_state_t  state, next_state;
  logic [RW-1:0] round_cnt;
  beat_t         beat_cnt;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= S_IDLE;
      round_cnt <= '0;
      beat_cnt  <= '0;
    end else if (set) begin
      state <= next_state;
      if (state == S_START_CAL)
        round_cnt <= round_cnt + 1'b1;
      beat_cnt <= (state == S_OUTPUT) ? beat_cnt + 1'b1 : '0; // cleared outside OUTPUT
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE:        if (hash_readin_ok) next_state = S_READY_INPUT;
      S_READY_INPUT: begin
        if (input_status == IN_STAGE && hash_cmd == CMD_RUN)
          next_state = S_INPUT;
      end
      S_INPUT:        if (input_status == IN_DONE) next_state = S_START_CAL;
      S_START_CAL:    next_state = S_CALCULATE;
      S_CALCULATE:    if (hash_done) next_state = S_OUTPUT_READY;
      S_OUTPUT_READY: if (cbd_status == ST_READY_INPUT) next_state = S_OUTPUT; // sampler waiting
      S_OUTPUT:       if (beat_cnt == beat_t'(HASH_BEATS - 1)) next_state = S_OUTPUT_DONE;
      S_OUTPUT_DONE: begin
        if (round_cnt == RW'(ROUNDS))
          next_state = S_SEQUENCE_DONE;
        else if (hash_cmd == CMD_RUN)
          next_state = S_START_CAL; // next squeeze, no reload
      end
      S_SEQUENCE_DONE: next_state = S_SEQUENCE_DONE;
      default:         next_state = S_IDLE;
    endcase
  end

  assign hash_sel     = (state == S_IDLE) && (hash_cmd == CMD_RUN);
  assign hash_readin  = (state == S_INPUT);
  assign hash_full_in = (state == S_START_CAL);
  assign hash_readout = (state == S_OUTPUT);

  always_comb begin
    case (state)
      S_READY_INPUT:            hash_status = ST_READY_INPUT;
      S_INPUT:                  hash_status = ST_INPUT;
      S_START_CAL, S_CALCULATE: hash_status = ST_CALC;
      S_OUTPUT_READY:           hash_status = ST_OUTPUT_READY;
      S_OUTPUT:                 hash_status = ST_OUTPUT;
      S_OUTPUT_DONE:            hash_status = ST_OUTPUT_DONE;
      S_SEQUENCE_DONE:          hash_status = ST_SEQ_DONE;
      default:                  hash_status = ST_IDLE;
    endcase
  end

endmodule

// ==== design/kyber_ctrl_pkg.sv ====
package kyber_ctrl_pkg;

  // sequencer to stage controller
  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_RUN
  } ctrl_cmd_t;

  // published by hash, cbd and ntt controllers
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_READY_INPUT,
    ST_INPUT,
    ST_CALC,
    ST_OUTPUT_READY,
    ST_OUTPUT,
    ST_OUTPUT_DONE,
    ST_SEQ_DONE
  } stage_status_t;

  // literals carry a prefix since all state sets share this package scope
  typedef enum logic [3:0] {
    S_IDLE,
    S_READY_INPUT,
    S_INPUT,
    S_START_CAL,
    S_CALCULATE,
    S_OUTPUT_READY,
    S_OUTPUT,
    S_OUTPUT_DONE,
    S_SEQUENCE_DONE
  } stage_state_t;

  typedef enum logic [1:0] {IN_IDLE, IN_STAGE, IN_ACTIVE, IN_DONE} input_status_t;
  typedef enum logic [2:0] {I_IDLE, I_CHOOSE, I_STAGE, I_READY, I_ACTIVE, I_DONE} input_state_t;
  typedef enum logic [1:0] {M_IDLE, M_RUN, M_STAGE, M_FINISH} main_state_t;

  typedef logic [7:0] beat_t;

  localparam int DEFAULT_ROUNDS      = 3;
  localparam int DEFAULT_HASH_BEATS  = 16;  // squeeze beats per round
  localparam int DEFAULT_COEFF_BEATS = 128; // ntt coefficients per round

endpackage

// ==== design/msg_input_fsm.sv ====
module msg_input_fsm (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          set,
  input  logic                          full_in,     // loader buffer full
  input  kyber_ctrl_pkg::ctrl_cmd_t     input_cmd,
  input  kyber_ctrl_pkg::stage_status_t hash_status,
  output logic                          readin_ok,
  output kyber_ctrl_pkg::input_status_t input_status
);
  import kyber_ctrl_pkg::*;

  input_state_t state, next_state;

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      state <= I_IDLE;
    else if (set)
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      I_IDLE: begin
        if (input_cmd == CMD_NONE) // only rearm once the command is cleared
          next_state = I_CHOOSE;
      end
      I_CHOOSE: begin
        if (input_cmd == CMD_RUN)
          next_state = I_STAGE;
      end
      I_STAGE: begin
        if (hash_status == ST_READY_INPUT)
          next_state = I_READY;
      end
      I_READY:  next_state = I_ACTIVE; // single cycle
      I_ACTIVE: if (full_in) next_state = I_DONE;
      I_DONE: begin
        if (hash_status == ST_CALC) // hash has absorbed the message
          next_state = I_IDLE;
      end
      default: next_state = I_IDLE;
    endcase
  end

  assign readin_ok = (state == I_READY);

  always_comb begin
    case (state)
      I_STAGE, I_READY: input_status = IN_STAGE;
      I_ACTIVE:         input_status = IN_ACTIVE;
      I_DONE:           input_status = IN_DONE;
      default:          input_status = IN_IDLE;
    endcase
  end

endmodule

// ==== design/ntt_stage_fsm.sv ====
module ntt_stage_fsm #(
  parameter int ROUNDS      = kyber_ctrl_pkg::DEFAULT_ROUNDS,
  parameter int COEFF_BEATS = kyber_ctrl_pkg::DEFAULT_COEFF_BEATS
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          set,
  input  logic                          ntt_ok_in,
  input  logic                          ntt_done,
  input  kyber_ctrl_pkg::ctrl_cmd_t     ntt_cmd,
  input  kyber_ctrl_pkg::stage_status_t cbd_status,
  output logic                          ntt_sel,
  output logic                          ntt_readin,
  output logic                          ntt_cal_en,
  output logic                          ntt_readout,
  output kyber_ctrl_pkg::stage_status_t ntt_status
);
  import kyber_ctrl_pkg::*;

  localparam int RW = $clog2(ROUNDS + 1);

  stage_state_t  state, next_state;
  logic [RW-1:0] round_cnt;
  beat_t         beat_cnt;   // coefficient index during OUTPUT

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= S_IDLE;
      round_cnt <= '0;
      beat_cnt  <= '0;
    end else if (set) begin
      state <= next_state;
      if (state == S_START_CAL)
        round_cnt <= round_cnt + 1'b1;
      beat_cnt <= (state == S_OUTPUT) ? beat_cnt + 1'b1 : '0;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE:        if (ntt_ok_in) next_state = S_READY_INPUT;
      S_READY_INPUT: begin
        if (cbd_status == ST_OUTPUT_READY && ntt_cmd == CMD_RUN)
          next_state = S_INPUT;
      end
      S_INPUT:        if (cbd_status == ST_OUTPUT_DONE) next_state = S_START_CAL; // poly loaded
      S_START_CAL:    next_state = S_CALCULATE;
      S_CALCULATE:    if (ntt_done) next_state = S_OUTPUT_READY;
      S_OUTPUT_READY: next_state = S_OUTPUT; // no downstream consumer to wait on
      S_OUTPUT:       if (beat_cnt == beat_t'(COEFF_BEATS - 1)) next_state = S_OUTPUT_DONE;
      S_OUTPUT_DONE: begin
        if (round_cnt == RW'(ROUNDS))
          next_state = S_SEQUENCE_DONE;
        else if (ntt_cmd == CMD_RUN)
          next_state = S_IDLE;
      end
      S_SEQUENCE_DONE: next_state = S_SEQUENCE_DONE;
      default:         next_state = S_IDLE;
    endcase
  end

  assign ntt_sel     = (state == S_IDLE) && (ntt_cmd == CMD_RUN);
  assign ntt_readin  = (state == S_INPUT);
  assign ntt_cal_en  = (state == S_START_CAL);
  assign ntt_readout = (state == S_OUTPUT);

  always_comb begin
    case (state)
      S_READY_INPUT:            ntt_status = ST_READY_INPUT;
      S_INPUT:                  ntt_status = ST_INPUT;
      S_START_CAL, S_CALCULATE: ntt_status = ST_CALC;
      S_OUTPUT_READY:           ntt_status = ST_OUTPUT_READY;
      S_OUTPUT:                 ntt_status = ST_OUTPUT;
      S_OUTPUT_DONE:            ntt_status = ST_OUTPUT_DONE;
      S_SEQUENCE_DONE:          ntt_status = ST_SEQ_DONE;
      default:                  ntt_status = ST_IDLE;
    endcase
  end

endmodule

// ==== design/pke_enc_ctrl.sv ====
module pke_enc_ctrl #(
  parameter int ROUNDS      = kyber_ctrl_pkg::DEFAULT_ROUNDS,
  parameter int HASH_BEATS  = kyber_ctrl_pkg::DEFAULT_HASH_BEATS,
  parameter int COEFF_BEATS = kyber_ctrl_pkg::DEFAULT_COEFF_BEATS
) (
  input  logic clk,
  input  logic reset,
  input  logic set,          // low freezes every controller
  input  logic full_in,
  input  logic hash_readin_ok,
  input  logic hash_done,
  input  logic cbd_ok_in,
  input  logic cbd_ok_out,
  input  logic ntt_ok_in,
  input  logic ntt_done,
  output logic readin_ok,
  output logic hash_sel,
  output logic hash_readin,
  output logic hash_full_in,
  output logic hash_readout,
  output logic cbd_sel,
  output logic cbd_readin,
  output logic cbd_readout,
  output logic ntt_sel,
  output logic ntt_readin,
  output logic ntt_cal_en,
  output logic ntt_readout,
  output logic done
);
  import kyber_ctrl_pkg::*;

  ctrl_cmd_t     input_cmd, hash_cmd, cbd_cmd, ntt_cmd;
  input_status_t input_status;
  stage_status_t hash_status, cbd_status, ntt_status;

  enc_sequencer u_enc_sequencer (
    .clk, .reset, .set, .input_status, .hash_status, .cbd_status, .ntt_status,
    .input_cmd, .hash_cmd, .cbd_cmd, .ntt_cmd, .done
  );

  msg_input_fsm u_msg_input_fsm (
    .clk, .reset, .set, .full_in, .input_cmd, .hash_status, .readin_ok, .input_status
  );

  hash_stage_fsm #(.ROUNDS(ROUNDS), .HASH_BEATS(HASH_BEATS)) u_hash_stage_fsm (
    .clk, .reset, .set, .hash_readin_ok, .hash_done, .hash_cmd, .input_status, .cbd_status,
    .hash_sel, .hash_readin, .hash_full_in, .hash_readout, .hash_status
  );

  cbd_stage_fsm #(.ROUNDS(ROUNDS)) u_cbd_stage_fsm (
    .clk, .reset, .set, .cbd_ok_in, .cbd_ok_out, .cbd_cmd, .hash_status, .ntt_status,
    .cbd_sel, .cbd_readin, .cbd_readout, .cbd_status
  );

  ntt_stage_fsm #(.ROUNDS(ROUNDS), .COEFF_BEATS(COEFF_BEATS)) u_ntt_stage_fsm (
    .clk, .reset, .set, .ntt_ok_in, .ntt_done, .ntt_cmd, .cbd_status,
    .ntt_sel, .ntt_readin, .ntt_cal_en, .ntt_readout, .ntt_status
  );

endmodule

// ==== pke_enc_ctrl.f ====
design/kyber_ctrl_pkg.sv
design/enc_sequencer.sv
design/msg_input_fsm.sv
design/hash_stage_fsm.sv
design/cbd_stage_fsm.sv
design/ntt_stage_fsm.sv
design/pke_enc_ctrl.sv
test/pke_enc_asserts.sv
test/pke_enc_checker.sv
test/tb_pke_enc_ctrl.sv

// ==== test/pke_enc_asserts.sv ====
module pke_enc_asserts (
  input logic clk,
  input logic reset,
  input logic set,
  input logic readin_ok,
  input logic hash_full_in,
  input logic hash_readout,
  input logic cbd_readout,
  input logic ntt_readout,
  input logic done
);
  int fail_count = 0;  // read by the testbench top

  // single-cycle strobes, a frozen cycle does not count
  readin_ok_single: assert property (@(posedge clk) disable iff (reset)
    (readin_ok && set) |=> !readin_ok)
    else begin
      fail_count++;
      $error("readin_ok high on two cycles in a row");
    end

  full_in_single: assert property (@(posedge clk) disable iff (reset)
    (hash_full_in && set) |=> !hash_full_in)
    else begin
      fail_count++;
      $error("hash_full_in high on two cycles in a row");
    end

  done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done)
    else begin
      fail_count++;
      $error("done fell without reset");
    end

  // first edge after release still sees the reset state
  reset_quiet: assert property (@(posedge clk)
    $fell(reset) |-> !(done || hash_readout || cbd_readout || ntt_readout))
    else begin
      fail_count++;
      $error("done or a readout strobe high right after reset");
    end

endmodule

// ==== test/pke_enc_checker.sv ====
module pke_enc_checker (
  input  logic clk,
  input  logic reset,
  input  logic set,
  input  logic readin_ok,
  input  logic hash_sel,
  input  logic hash_readin,
  input  logic hash_full_in,
  input  logic hash_readout,
  input  logic cbd_sel,
  input  logic cbd_readin,
  input  logic cbd_readout,
  input  logic ntt_sel,
  input  logic ntt_readin,
  input  logic ntt_cal_en,
  input  logic ntt_readout,
  input  logic done,
  input  logic report,      // end of test
  input  logic summary,     // end of run
  input  int   test_num,
  input  int   exp_full,
  input  int   exp_hread,
  input  int   exp_nread,
  input  int   exp_cbd,
  input  int   exp_readin,
  output int   error_count
);
  int          n_full, n_hread, n_nread, n_cbd, n_readin, n_cal;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        cbd_readout_q, prev_set, hold_valid;
  logic [12:0] outs, prev_outs;

  assign outs = {readin_ok, hash_sel, hash_readin, hash_full_in, hash_readout, cbd_sel,
                 cbd_readin, cbd_readout, ntt_sel, ntt_readin, ntt_cal_en, ntt_readout, done};

  initial error_count = 0;

  task automatic compare_count(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h (test %0d)", name, got, expected, test_num);
      test_errors++;
    end
  endtask

  // falling-edge sampling so set matches the next rising edge
  always @(negedge clk) begin
    if (reset) begin
      if (outs !== 13'h0) begin
        $display("** Error: outputs in reset = 0x%h, expected 0x%h", outs, 13'h0);
        test_errors++;
      end
      n_full = 0;
      n_hread = 0;
      n_nread = 0;
      n_cbd = 0;
      n_readin = 0;
      n_cal = 0;
      cbd_readout_q = 1'b0;
      hold_valid = 1'b0;
    end else begin
      if (hold_valid && !prev_set && outs !== prev_outs) begin
        $display("** Error: outputs with set low = 0x%h, expected 0x%h", outs, prev_outs);
        test_errors++;
      end
      if (set) begin
        n_full += hash_full_in;
        n_hread += hash_readout;
        n_nread += ntt_readout;
        n_readin += readin_ok;
        n_cal += ntt_cal_en;
      end
      if (cbd_readout && !cbd_readout_q)
        n_cbd++;  // one per burst
      cbd_readout_q = cbd_readout;
      prev_outs = outs;
      prev_set = set;
      hold_valid = 1'b1;
    end

    if (report) begin
      tests_run++;
      compare_count("hash_full_in", n_full, exp_full);
      compare_count("hash_readout", n_hread, exp_hread);
      compare_count("ntt_readout", n_nread, exp_nread);
      compare_count("cbd_readout", n_cbd, exp_cbd);
      compare_count("readin_ok", n_readin, exp_readin);
      compare_count("ntt_cal_en", n_cal, exp_full);  // one per round like hash_full_in
      if (done !== 1'b1) begin
        $display("test %0d: done did not stay high after it rose", test_num);
        test_errors++;
      end
      if (test_errors != 0)
        tests_failed++;
      $display("test %0d %s: full_in %0d, hash beats %0d, ntt beats %0d, cbd bursts %0d",
               test_num, (test_errors == 0) ? "ok" : "failed", n_full, n_hread, n_nread, n_cbd);
      error_count += test_errors;
      test_errors = 0;
    end

    if (summary) begin
      error_count += test_errors;
      test_errors = 0;
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    end
  end

endmodule

// ==== test/pke_enc_trace.txt ====
// test full_dly hash_lat cbd_lat ntt_lat cbd_win frz_start frz_len, all hex
// then expected: hash_full_in pulses, hash_readout, ntt_readout, cbd bursts, readin_ok
01 02 04 03 05 04 00 00 03 30 180 03 01
02 00 01 01 01 01 00 00 03 30 180 03 01
03 05 0c 08 10 06 28 14 03 30 180 03 01
04 03 06 02 03 0a 80 30 03 30 180 03 01
05 01 02 10 07 02 12c 08 03 30 180 03 01
00 00 00 00 00 00 00 00 00 00 00 00 00

// ==== test/tb_pke_enc_ctrl.sv ====
module tb_pke_enc_ctrl;
  import kyber_ctrl_pkg::*;

  localparam int ROUNDS       = DEFAULT_ROUNDS;
  localparam int HASH_BEATS   = DEFAULT_HASH_BEATS;
  localparam int COEFF_BEATS  = DEFAULT_COEFF_BEATS;
  localparam int NCOL         = 13;  // values per trace line
  localparam int MAX_TESTS    = 16;
  localparam int RESET_CYCLES = 4;

  logic clk;
  logic reset = 1'b1;
  logic set = 1'b1;
  logic full_in = 1'b0;
  logic hash_readin_ok = 1'b0;
  logic hash_done = 1'b0;
  logic cbd_ok_in = 1'b0;
  logic cbd_ok_out = 1'b0;
  logic ntt_ok_in = 1'b0;
  logic ntt_done = 1'b0;
  logic readin_ok, hash_sel, hash_readin, hash_full_in, hash_readout;
  logic cbd_sel, cbd_readin, cbd_readout;
  logic ntt_sel, ntt_readin, ntt_cal_en, ntt_readout, done;
  logic report = 1'b0;
  logic summary = 1'b0;
  int   check_errors;

  logic [15:0] trace_mem [0:NCOL*MAX_TESTS-1];
  int     num_tests;
  int     budget_cycles = 0;
  int     cur_test, full_dly, hash_lat, cbd_lat, ntt_lat, cbd_win, frz_start, frz_len;
  int     exp_full, exp_hread, exp_nread, exp_cbd, exp_readin;
  integer seed = 32'h9860;

  // responder state
  int   cyc, full_cnt, hd_cnt, co_cnt, nd_cnt, win_cnt;
  logic full_pend, hd_pend, co_pend, nd_pend;
  logic readin_ok_q, hash_full_in_q, cbd_readin_q, ntt_cal_en_q;

  pke_enc_ctrl #(.ROUNDS(ROUNDS), .HASH_BEATS(HASH_BEATS), .COEFF_BEATS(COEFF_BEATS))
  u_pke_enc_ctrl (
    .clk, .reset, .set, .full_in, .hash_readin_ok, .hash_done, .cbd_ok_in, .cbd_ok_out,
    .ntt_ok_in, .ntt_done, .readin_ok, .hash_sel, .hash_readin, .hash_full_in,
    .hash_readout, .cbd_sel, .cbd_readin, .cbd_readout, .ntt_sel, .ntt_readin,
    .ntt_cal_en, .ntt_readout, .done
  );

  pke_enc_checker u_checker (
    .clk, .reset, .set, .readin_ok, .hash_sel, .hash_readin, .hash_full_in, .hash_readout,
    .cbd_sel, .cbd_readin, .cbd_readout, .ntt_sel, .ntt_readin, .ntt_cal_en, .ntt_readout,
    .done, .report, .summary, .test_num(cur_test), .exp_full, .exp_hread, .exp_nread,
    .exp_cbd, .exp_readin, .error_count(check_errors)
  );

  bind pke_enc_ctrl pke_enc_asserts u_asserts (
    .clk, .reset, .set, .readin_ok, .hash_full_in, .hash_readout, .cbd_readout,
    .ntt_readout, .done
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int extra_delay();
    return $random(seed) & 3;
  endfunction

  // datapath model, each flag follows its strobe after the trace latency
  always @(posedge clk) begin
    if (reset) begin
      {full_in, hash_readin_ok, hash_done, cbd_ok_in, cbd_ok_out, ntt_ok_in, ntt_done} <= '0;
      {full_pend, hd_pend, co_pend, nd_pend} <= '0;
      {readin_ok_q, hash_full_in_q, cbd_readin_q, ntt_cal_en_q} <= '0;
      set <= 1'b1;
      cyc <= 0;
      win_cnt <= 0;
    end else begin
      cyc <= cyc + 1;
      set <= (frz_len == 0) || (cyc < frz_start) || (cyc >= frz_start + frz_len);
      hash_readin_ok <= hash_sel;
      cbd_ok_in <= cbd_sel;
      ntt_ok_in <= ntt_sel;
      readin_ok_q <= readin_ok;
      hash_full_in_q <= hash_full_in;
      cbd_readin_q <= cbd_readin;
      ntt_cal_en_q <= ntt_cal_en;

      if (readin_ok && !readin_ok_q) begin  // loader fills the buffer
        full_pend <= 1'b1;
        full_cnt <= full_dly + extra_delay();
      end else if (full_pend) begin
        if (full_cnt == 0) begin
          full_in <= 1'b1;
          full_pend <= 1'b0;
        end else
          full_cnt <= full_cnt - 1;
      end
      if (hash_full_in)
        full_in <= 1'b0;

      if (hash_full_in && !hash_full_in_q) begin
        hd_pend <= 1'b1;
        hd_cnt <= hash_lat + extra_delay();
      end else if (hd_pend) begin
        if (hd_cnt == 0) begin
          hash_done <= 1'b1;
          hd_pend <= 1'b0;
        end else
          hd_cnt <= hd_cnt - 1;
      end
      if (hash_readout)
        hash_done <= 1'b0;

      if (!cbd_readin && cbd_readin_q) begin  // sampler starts once readin ends
        co_pend <= 1'b1;
        co_cnt <= cbd_lat + extra_delay();
        win_cnt <= 0;
      end else if (co_pend) begin
        if (co_cnt == 0) begin
          cbd_ok_out <= 1'b1;
          co_pend <= 1'b0;
        end else
          co_cnt <= co_cnt - 1;
      end
      if (cbd_ok_out && cbd_readout && set) begin
        if (win_cnt + 1 >= cbd_win)
          cbd_ok_out <= 1'b0;  // sample window closes
        win_cnt <= win_cnt + 1;
      end

      if (ntt_cal_en && !ntt_cal_en_q) begin
        nd_pend <= 1'b1;
        nd_cnt <= ntt_lat + extra_delay();
      end else if (nd_pend) begin
        if (nd_cnt == 0) begin
          ntt_done <= 1'b1;
          nd_pend <= 1'b0;
        end else
          nd_cnt <= nd_cnt - 1;
      end
      if (ntt_readout)
        ntt_done <= 1'b0;
    end
  end

  task automatic load_trace();
    int base;
    int total;
    $readmemh("test/pke_enc_trace.txt", trace_mem);
    num_tests = 0;
    total = 0;
    while (num_tests < MAX_TESTS && trace_mem[num_tests*NCOL] !== 16'h0 &&
           !$isunknown(trace_mem[num_tests*NCOL])) begin
      base = num_tests * NCOL;
      total += 4 * (ROUNDS * (trace_mem[base+1] + trace_mem[base+2] + trace_mem[base+3] +
               trace_mem[base+4] + trace_mem[base+5] + HASH_BEATS + COEFF_BEATS) +
               trace_mem[base+7]) + RESET_CYCLES + 8;
      num_tests++;
    end
    if (num_tests == 0)
      $display("trace file holds no tests");
    budget_cycles = total;
  endtask

  task automatic run_test(input int t);
    int base;
    base = t * NCOL;
    @(posedge clk);
    reset <= 1'b1;
    cur_test <= trace_mem[base];
    full_dly <= trace_mem[base+1];
    hash_lat <= trace_mem[base+2];
    cbd_lat <= trace_mem[base+3];
    ntt_lat <= trace_mem[base+4];
    cbd_win <= trace_mem[base+5];
    frz_start <= trace_mem[base+6];
    frz_len <= trace_mem[base+7];
    exp_full <= trace_mem[base+8];
    exp_hread <= trace_mem[base+9];
    exp_nread <= trace_mem[base+10];
    exp_cbd <= trace_mem[base+11];
    exp_readin <= trace_mem[base+12];
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    while (done !== 1'b1)
      @(posedge clk);
    repeat (4) @(posedge clk);  // let the last strobes settle
    report <= 1'b1;
    @(posedge clk);
    report <= 1'b0;
  endtask

  initial begin
    load_trace();
    for (int t = 0; t < num_tests; t++)
      run_test(t);
    @(posedge clk);
    summary <= 1'b1;
    @(posedge clk);
    summary <= 1'b0;
    @(posedge clk);
    if (num_tests > 0 && check_errors == 0 && u_pke_enc_ctrl.u_asserts.fail_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", budget_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
